// ==== rtl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	localparam reg_addr_t ZERO_REG = 5'd0;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;

	// function field under OP_SPECIAL
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_MOVZ = 6'b001010;
	localparam logic [5:0] FN_MOVN = 6'b001011;
	localparam logic [5:0] FN_SYNC = 6'b001111;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	typedef enum logic [3:0] {
		ALU_OR,
		ALU_AND,
		ALU_XOR,
		ALU_NOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_ADD,
		ALU_SUB,
		ALU_MOVN,
		ALU_MOVZ,
		ALU_NOP
	} alu_op_t;

	typedef struct packed {
		alu_op_t   op;
		word_t     a;       // rs value, or shift amount for sll/srl/sra
		word_t     b;       // rt value or immediate
		reg_addr_t dest;
		logic      wr_en;
		logic      invalid;
	} ex_req_t;

	typedef struct packed {
		reg_addr_t dest;
		word_t     value;
		logic      wr_en;
		logic      invalid;
	} wb_rec_t;

endpackage

`default_nettype wire

// ==== rtl/stage_reg.sv ====
`default_nettype none

module stage_reg #(
	parameter type payload_t = logic
) (
	input  wire       clk,
	input  wire       arst_n_i,

	input  wire       in_valid_i,
	input  wire       payload_t in_data_i,
	output logic      in_ready_o,

	output logic      out_valid_o,
	output payload_t  out_data_o,
	input  wire       out_ready_i
);

	logic     full_q;
	payload_t data_q;

	// accept when empty or when the held entry leaves this cycle
	assign in_ready_o = !full_q || out_ready_i;

	assign out_valid_o = full_q;
	assign out_data_o  = data_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			full_q <= 1'b0;
		end else if (in_ready_o) begin
			full_q <= in_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_data_i;
		end
	end

	// stalled output must hold still until taken
	a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`default_nettype none

module decode_stage (
	input  wire                        inst_valid_i,
	input  wire mips_pkg::word_t       inst_i,
	output logic                       inst_ready_o,

	output mips_pkg::reg_addr_t        rs_addr_o,
	output mips_pkg::reg_addr_t        rt_addr_o,
	input  wire mips_pkg::word_t       rs_data_i,
	input  wire mips_pkg::word_t       rt_data_i,

	input  wire                        ex_fwd_valid_i,
	input  wire mips_pkg::wb_rec_t     ex_fwd_i,
	input  wire                        wb_fwd_valid_i,
	input  wire mips_pkg::wb_rec_t     wb_fwd_i,

	output logic                       req_valid_o,
	output mips_pkg::ex_req_t          req_o,
	input  wire                        req_ready_i
);

	logic [5:0]          opcode;
	logic [5:0]          funct;
	logic [4:0]          shamt;
	logic [15:0]         imm16;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	mips_pkg::word_t     rs_val;
	mips_pkg::word_t     rt_val;
	mips_pkg::word_t     a_imm;
	mips_pkg::word_t     b_imm;
	logic                a_use_imm;
	logic                b_use_imm;
	logic                shift_imm;
	mips_pkg::alu_op_t   op_sel;
	mips_pkg::reg_addr_t dest_sel;
	logic                wr_en;
	logic                invalid;

	// execute record first, then the result record, then the register file
	function automatic mips_pkg::word_t fwd_pick(
		input mips_pkg::reg_addr_t addr,
		input mips_pkg::word_t     rf_data,
		input logic                ex_v,
		input mips_pkg::wb_rec_t   ex_rec,
		input logic                wb_v,
		input mips_pkg::wb_rec_t   wb_rec
	);
		if (addr == mips_pkg::ZERO_REG)
			return '0;
		if (ex_v && ex_rec.wr_en && ex_rec.dest == addr)
			return ex_rec.value;
		if (wb_v && wb_rec.wr_en && wb_rec.dest == addr)
			return wb_rec.value;
		return rf_data;
	endfunction

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];
	assign imm16  = inst_i[15:0];

	assign rs_addr_o = rs;
	assign rt_addr_o = rt;

	assign rs_val = fwd_pick(rs, rs_data_i, ex_fwd_valid_i, ex_fwd_i, wb_fwd_valid_i, wb_fwd_i);
	assign rt_val = fwd_pick(rt, rt_data_i, ex_fwd_valid_i, ex_fwd_i, wb_fwd_valid_i, wb_fwd_i);

	assign shift_imm = (funct == mips_pkg::FN_SLL) || (funct == mips_pkg::FN_SRL) ||
		(funct == mips_pkg::FN_SRA);

	always_comb begin
		op_sel    = mips_pkg::ALU_NOP;
		dest_sel  = rd;
		wr_en     = 1'b0;
		invalid   = 1'b0;
		a_use_imm = 1'b0;
		b_use_imm = 1'b0;
		a_imm     = '0;
		b_imm     = '0;
		if (inst_i != '0) begin    // all-zero word stays a nop
			case (opcode)
				mips_pkg::OP_SPECIAL: begin
					a_use_imm = shift_imm;
					a_imm     = {27'd0, shamt};
					if (shift_imm ? (rs != mips_pkg::ZERO_REG) : (shamt != 5'd0)) begin
						invalid = 1'b1;
					end else begin
						wr_en = 1'b1;
						case (funct)
							mips_pkg::FN_OR:   op_sel = mips_pkg::ALU_OR;
							mips_pkg::FN_AND:  op_sel = mips_pkg::ALU_AND;
							mips_pkg::FN_XOR:  op_sel = mips_pkg::ALU_XOR;
							mips_pkg::FN_NOR:  op_sel = mips_pkg::ALU_NOR;
							mips_pkg::FN_SLL,
							mips_pkg::FN_SLLV: op_sel = mips_pkg::ALU_SLL;
							mips_pkg::FN_SRL,
							mips_pkg::FN_SRLV: op_sel = mips_pkg::ALU_SRL;
							mips_pkg::FN_SRA,
							mips_pkg::FN_SRAV: op_sel = mips_pkg::ALU_SRA;
							mips_pkg::FN_SLT:  op_sel = mips_pkg::ALU_SLT;
							mips_pkg::FN_SLTU: op_sel = mips_pkg::ALU_SLTU;
							mips_pkg::FN_ADD,
							mips_pkg::FN_ADDU: op_sel = mips_pkg::ALU_ADD;   // no overflow trap
							mips_pkg::FN_SUB,
							mips_pkg::FN_SUBU: op_sel = mips_pkg::ALU_SUB;
							mips_pkg::FN_MOVN: begin
								op_sel = mips_pkg::ALU_MOVN;
								wr_en  = (rt_val != '0);
							end
							mips_pkg::FN_MOVZ: begin
								op_sel = mips_pkg::ALU_MOVZ;
								wr_en  = (rt_val == '0);
							end
							mips_pkg::FN_SYNC: wr_en = 1'b0;
							default: begin
								wr_en   = 1'b0;
								invalid = 1'b1;
							end
						endcase
					end
				end
				mips_pkg::OP_ORI:   op_sel = mips_pkg::ALU_OR;
				mips_pkg::OP_ANDI:  op_sel = mips_pkg::ALU_AND;
				mips_pkg::OP_XORI:  op_sel = mips_pkg::ALU_XOR;
				mips_pkg::OP_LUI: begin
					op_sel    = mips_pkg::ALU_OR;
					a_use_imm = 1'b1;    // or with zero
				end
				mips_pkg::OP_SLTI:  op_sel = mips_pkg::ALU_SLT;
				mips_pkg::OP_SLTIU: op_sel = mips_pkg::ALU_SLTU;
				mips_pkg::OP_ADDI,
				mips_pkg::OP_ADDIU: op_sel = mips_pkg::ALU_ADD;
				default:            invalid = 1'b1;
			endcase
			if (opcode != mips_pkg::OP_SPECIAL && !invalid) begin
				dest_sel  = rt;
				wr_en     = 1'b1;
				b_use_imm = 1'b1;
				case (opcode)
					mips_pkg::OP_ORI,
					mips_pkg::OP_ANDI,
					mips_pkg::OP_XORI: b_imm = {16'h0000, imm16};
					mips_pkg::OP_LUI:  b_imm = {imm16, 16'h0000};
					default:           b_imm = {{16{imm16[15]}}, imm16};
				endcase
			end
		end
	end

	assign req_o = '{
		op:      op_sel,
		a:       a_use_imm ? a_imm : rs_val,
		b:       b_use_imm ? b_imm : rt_val,
		dest:    dest_sel,
		wr_en:   wr_en,
		invalid: invalid
	};

	assign req_valid_o  = inst_valid_i;
	assign inst_ready_o = req_ready_i;

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`default_nettype none

module execute_stage (
	input  wire                      req_valid_i,
	input  wire mips_pkg::ex_req_t   req_i,
	output logic                     req_ready_o,

	output logic                     res_valid_o,
	output mips_pkg::wb_rec_t        res_o,
	input  wire                      res_ready_i,

	output mips_pkg::wb_rec_t        fwd_o
);

	mips_pkg::word_t a;
	mips_pkg::word_t b;
	mips_pkg::word_t value;
	logic [4:0]      sh;

	assign a  = req_i.a;
	assign b  = req_i.b;
	assign sh = a[4:0];

	always_comb begin
		case (req_i.op)
			mips_pkg::ALU_OR:   value = a | b;
			mips_pkg::ALU_AND:  value = a & b;
			mips_pkg::ALU_XOR:  value = a ^ b;
			mips_pkg::ALU_NOR:  value = ~(a | b);
			mips_pkg::ALU_SLL:  value = b << sh;
			mips_pkg::ALU_SRL:  value = b >> sh;
			mips_pkg::ALU_SRA:  value = $signed(b) >>> sh;
			mips_pkg::ALU_SLT:  value = {31'd0, $signed(a) < $signed(b)};
			mips_pkg::ALU_SLTU: value = {31'd0, a < b};
			mips_pkg::ALU_ADD:  value = a + b;
			mips_pkg::ALU_SUB:  value = a - b;
			// move condition already folded into wr_en
			mips_pkg::ALU_MOVN,
			mips_pkg::ALU_MOVZ: value = a;
			default:            value = '0;
		endcase
	end

	assign res_o = '{
		dest:    req_i.dest,
		value:   value,
		wr_en:   req_i.wr_en,
		invalid: req_i.invalid
	};

	// decode sees the same record for forwarding
	assign fwd_o = res_o;

	assign res_valid_o = req_valid_i;
	assign req_ready_o = res_ready_i;

endmodule

`default_nettype wire

// ==== rtl/writeback_stage.sv ====
`default_nettype none

module writeback_stage (
	input  wire                        clk,
	input  wire                        arst_n_i,

	input  wire                        rec_valid_i,
	input  wire mips_pkg::wb_rec_t     rec_i,
	output logic                       rec_ready_o,

	output logic                       res_valid_o,
	output mips_pkg::wb_rec_t          res_o,
	input  wire                        res_ready_i,

	input  wire mips_pkg::reg_addr_t   rs_addr_i,
	input  wire mips_pkg::reg_addr_t   rt_addr_i,
	output mips_pkg::word_t            rs_data_o,
	output mips_pkg::word_t            rt_data_o
);

	mips_pkg::word_t regs_q [1:31];    // r0 is not stored
	logic            rf_we;

	// commit only when the record is taken
	assign rf_we = rec_valid_i && res_ready_i && rec_i.wr_en &&
		(rec_i.dest != mips_pkg::ZERO_REG);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (rf_we) begin
			regs_q[rec_i.dest] <= rec_i.value;
		end
	end

	assign rs_data_o = (rs_addr_i == mips_pkg::ZERO_REG) ? '0 : regs_q[rs_addr_i];
	assign rt_data_o = (rt_addr_i == mips_pkg::ZERO_REG) ? '0 : regs_q[rt_addr_i];

	assign res_valid_o = rec_valid_i;
	assign res_o       = rec_i;
	assign rec_ready_o = res_ready_i;

	// an invalid instruction decoded two stages back must never reach the file
	a_no_invalid_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		rf_we |-> !rec_i.invalid);

endmodule

`default_nettype wire

// ==== rtl/mips_core.sv ====
`default_nettype none

module mips_core (
	input  wire                    clk,
	input  wire                    arst_n_i,

	input  wire                    inst_valid_i,
	input  wire mips_pkg::word_t   inst_i,
	output logic                   inst_ready_o,

	output logic                   res_valid_o,
	output mips_pkg::wb_rec_t      res_o,
	input  wire                    res_ready_i
);

	mips_pkg::reg_addr_t rs_addr;
	mips_pkg::reg_addr_t rt_addr;
	mips_pkg::word_t     rs_data;
	mips_pkg::word_t     rt_data;

	logic                dec_valid;
	logic                dec_ready;
	mips_pkg::ex_req_t   dec_req;

	logic                ex_valid;
	logic                ex_ready;
	mips_pkg::ex_req_t   ex_req;

	logic                alu_valid;
	logic                alu_ready;
	mips_pkg::wb_rec_t   alu_rec;
	mips_pkg::wb_rec_t   ex_fwd;

	logic                wb_valid;
	logic                wb_ready;
	mips_pkg::wb_rec_t   wb_rec;

	decode_stage u_decode (
		.inst_valid_i   (inst_valid_i),
		.inst_i         (inst_i),
		.inst_ready_o   (inst_ready_o),
		.rs_addr_o      (rs_addr),
		.rt_addr_o      (rt_addr),
		.rs_data_i      (rs_data),
		.rt_data_i      (rt_data),
		.ex_fwd_valid_i (ex_valid),
		.ex_fwd_i       (ex_fwd),
		.wb_fwd_valid_i (wb_valid),
		.wb_fwd_i       (wb_rec),
		.req_valid_o    (dec_valid),
		.req_o          (dec_req),
		.req_ready_i    (dec_ready)
	);

	stage_reg #(.payload_t(mips_pkg::ex_req_t)) u_ex_reg (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.in_valid_i  (dec_valid),
		.in_data_i   (dec_req),
		.in_ready_o  (dec_ready),
		.out_valid_o (ex_valid),
		.out_data_o  (ex_req),
		.out_ready_i (ex_ready)
	);

	execute_stage u_execute (
		.req_valid_i (ex_valid),
		.req_i       (ex_req),
		.req_ready_o (ex_ready),
		.res_valid_o (alu_valid),
		.res_o       (alu_rec),
		.res_ready_i (alu_ready),
		.fwd_o       (ex_fwd)
	);

	stage_reg #(.payload_t(mips_pkg::wb_rec_t)) u_wb_reg (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.in_valid_i  (alu_valid),
		.in_data_i   (alu_rec),
		.in_ready_o  (alu_ready),
		.out_valid_o (wb_valid),
		.out_data_o  (wb_rec),
		.out_ready_i (wb_ready)
	);

	writeback_stage u_writeback (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.rec_valid_i (wb_valid),
		.rec_i       (wb_rec),
		.rec_ready_o (wb_ready),
		.res_valid_o (res_valid_o),
		.res_o       (res_o),
		.res_ready_i (res_ready_i),
		.rs_addr_i   (rs_addr),
		.rt_addr_i   (rt_addr),
		.rs_data_o   (rs_data),
		.rt_data_o   (rt_data)
	);

endmodule

`default_nettype wire

// ==== sim/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

mips_pkg::word_t mirror [32];    // architectural state in program order
logic [15:0]     lfsr_q = 16'd75;
int              errors = 0;
int              checks = 0;

// 16 bit fibonacci, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_next(lfsr_q);
		v      = {v[30:0], lfsr_q[0]};
	end
	return v;
endfunction

task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
	end
endtask

// expected record for one instruction, mirror updated as a side effect
function automatic mips_pkg::wb_rec_t ref_result(input mips_pkg::word_t inst);
	mips_pkg::wb_rec_t r;
	mips_pkg::word_t   a;
	mips_pkg::word_t   b;
	mips_pkg::word_t   se;
	logic [4:0]        sa;
	a         = mirror[inst[25:21]];
	b         = mirror[inst[20:16]];
	se        = {{16{inst[15]}}, inst[15:0]};
	sa        = inst[10:6];
	r.dest    = inst[20:16];    // immediate forms write rt
	r.value   = '0;
	r.wr_en   = 1'b1;
	r.invalid = 1'b0;
	if (inst[31:26] == mips_pkg::OP_SPECIAL) begin
		r.dest = inst[15:11];
		case (inst[5:0])
			mips_pkg::FN_OR:   r.value = a | b;
			mips_pkg::FN_AND:  r.value = a & b;
			mips_pkg::FN_XOR:  r.value = a ^ b;
			mips_pkg::FN_NOR:  r.value = ~(a | b);
			mips_pkg::FN_SLL:  r.value = b << sa;
			mips_pkg::FN_SRL:  r.value = b >> sa;
			mips_pkg::FN_SRA:  r.value = $signed(b) >>> sa;
			mips_pkg::FN_SLLV: r.value = b << a[4:0];
			mips_pkg::FN_SRLV: r.value = b >> a[4:0];
			mips_pkg::FN_SRAV: r.value = $signed(b) >>> a[4:0];
			mips_pkg::FN_SLT:  r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			mips_pkg::FN_SLTU: r.value = (a < b) ? 32'd1 : 32'd0;
			mips_pkg::FN_ADD, mips_pkg::FN_ADDU: r.value = a + b;
			mips_pkg::FN_SUB, mips_pkg::FN_SUBU: r.value = a - b;
			mips_pkg::FN_MOVN: begin
				r.value = a;
				r.wr_en = (b != '0);
			end
			mips_pkg::FN_MOVZ: begin
				r.value = a;
				r.wr_en = (b == '0);
			end
			mips_pkg::FN_SYNC: r.wr_en = 1'b0;
			default:           r.invalid = 1'b1;
		endcase
		if (inst == '0)
			r.wr_en = 1'b0;    // nop
	end else begin
		case (inst[31:26])
			mips_pkg::OP_ORI:   r.value = a | {16'h0000, inst[15:0]};
			mips_pkg::OP_ANDI:  r.value = a & {16'h0000, inst[15:0]};
			mips_pkg::OP_XORI:  r.value = a ^ {16'h0000, inst[15:0]};
			mips_pkg::OP_LUI:   r.value = {inst[15:0], 16'h0000};
			mips_pkg::OP_SLTI:  r.value = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
			mips_pkg::OP_SLTIU: r.value = (a < se) ? 32'd1 : 32'd0;
			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: r.value = a + se;
			default:            r.invalid = 1'b1;
		endcase
	end
	if (r.invalid)
		r.wr_en = 1'b0;
	if (r.wr_en && r.dest != mips_pkg::ZERO_REG)
		mirror[r.dest] = r.value;    // r0 stays zero
	return r;
endfunction

`endif

// ==== sim/tb_mips_core.sv ====
`default_nettype none

module tb_mips_core;
	timeunit 1ns;
	timeprecision 1ps;

	logic              clk;
	logic              arst_n;
	logic              inst_valid;
	mips_pkg::word_t   inst_data;
	logic              inst_ready;
	logic              res_valid;
	mips_pkg::wb_rec_t res_rec;
	logic              res_ready;

	mips_pkg::word_t   inst_q [$];    // accepted, not yet retired
	int                cyc_q [$];
	int                cycles = 0;
	logic              bp_on = 1'b0;
	logic              lat_check = 1'b0;

	`include "tb_ref_model.svh"

	localparam logic [15:0][5:0] RR_FNS = {mips_pkg::FN_OR, mips_pkg::FN_AND,
		mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_SLLV, mips_pkg::FN_SRLV,
		mips_pkg::FN_SRAV, mips_pkg::FN_SLT, mips_pkg::FN_SLTU, mips_pkg::FN_ADD,
		mips_pkg::FN_ADDU, mips_pkg::FN_SUB, mips_pkg::FN_SUBU, mips_pkg::FN_MOVN,
		mips_pkg::FN_MOVZ, mips_pkg::FN_SYNC};
	localparam logic [7:0][5:0] IMM_OPS = {mips_pkg::OP_ORI, mips_pkg::OP_ANDI,
		mips_pkg::OP_XORI, mips_pkg::OP_LUI, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
		mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU};
	localparam logic [2:0][5:0] SH_FNS = {mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA};

	mips_core u_dut (
		.clk          (clk),
		.arst_n_i     (arst_n),
		.inst_valid_i (inst_valid),
		.inst_i       (inst_data),
		.inst_ready_o (inst_ready),
		.res_valid_o  (res_valid),
		.res_o        (res_rec),
		.res_ready_i  (res_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycles <= cycles + 1;

	task automatic abort(input string what);
		$display("Timed out waiting for %s.", what);
		$display("Finished with errors");
		$finish;
	endtask

	task automatic drive_ready();
		res_ready = bp_on ? (rand_bits(2) != 0) : 1'b1;    // stalls one cycle in four
	endtask

	task automatic idle();
		@(negedge clk);
		inst_valid = 1'b0;
		drive_ready();
	endtask

	// returns just before the transfer edge
	task automatic send(input mips_pkg::word_t inst);
		int wait_cnt;
		wait_cnt = 0;
		@(negedge clk);
		inst_valid = 1'b1;
		inst_data  = inst;
		drive_ready();
		#1;
		while (!inst_ready) begin
			wait_cnt++;
			if (wait_cnt > 100)
				abort("inst_ready to accept an instruction");
			@(negedge clk);
			drive_ready();
			#1;
		end
		inst_q.push_back(inst);
		cyc_q.push_back(cycles);
	endtask

	task automatic drain(input string name);
		int wait_cnt;
		wait_cnt = 0;
		idle();
		while (inst_q.size() != 0) begin
			wait_cnt++;
			if (wait_cnt > 200)
				abort("the result records of the outstanding instructions");
			idle();
		end
		$display("test %s finished, %0d errors so far", name, errors);
	endtask

	function automatic mips_pkg::word_t rand_inst();
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		logic [1:0]  kind;
		rs   = 5'(rand_bits(3));    // r0..r7 keeps dependences dense
		rt   = 5'(rand_bits(3));
		rd   = 5'(rand_bits(3));
		imm  = 16'(rand_bits(16));
		kind = 2'(rand_bits(2));
		if (kind == 2'd0)
			return {mips_pkg::OP_SPECIAL, 5'd0, rt, rd, imm[10:6], SH_FNS[rand_bits(5) % 3]};
		if (kind == 2'd1)
			return {IMM_OPS[rand_bits(3)], rs, rt, imm};
		return {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, RR_FNS[rand_bits(4)]};
	endfunction

	// result side, sampled mid cycle after the inputs have settled
	initial begin
		mips_pkg::word_t   inst;
		mips_pkg::wb_rec_t exp;
		string             tag;
		int                lat;
		forever begin
			@(negedge clk);
			#2;
			if (arst_n && !inst_ready)
				check_eq(32'(res_valid && !res_ready), 32'd1, "inst_ready low, result not stalled");
			if (res_valid && res_ready) begin
				if (inst_q.size() == 0) begin
					errors++;
					$display("A result record came out at %0t with nothing outstanding.", $time);
				end else begin
					inst = inst_q.pop_front();
					lat  = cycles - cyc_q.pop_front();
					exp  = ref_result(inst);
					tag  = $sformatf("inst %h", inst);
					if (lat_check)
						check_eq(lat, 32'd2, {tag, " latency"});
					check_eq(32'(res_rec.invalid), 32'(exp.invalid), {tag, " invalid"});
					check_eq(32'(res_rec.wr_en), 32'(exp.wr_en), {tag, " wr_en"});
					if (!exp.invalid)
						check_eq(32'(res_rec.dest), 32'(exp.dest), {tag, " dest"});
					if (exp.wr_en)
						check_eq(res_rec.value, exp.value, {tag, " value"});
				end
			end
		end
	end

	initial begin
		logic [4:0] prev;
		logic [4:0] prev2;
		logic [4:0] d;
		logic [15:0] imm;
		inst_valid = 1'b0;
		inst_data  = '0;
		res_ready  = 1'b1;
		arst_n     = 1'b0;
		foreach (mirror[i])
			mirror[i] = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		check_eq(32'(res_valid), 32'd0, "res_valid after reset");
		for (int i = 0; i < 32; i++)
			send({mips_pkg::OP_SPECIAL, 5'(i), 5'd0, 5'(i), 5'd0, mips_pkg::FN_OR});
		drain("reset_state");

		lat_check = 1'b1;
		repeat (200) send(rand_inst());
		drain("random_mix");

		// each one reads the last two destinations, one per forwarding source
		prev  = 5'd1;
		prev2 = 5'd2;
		for (int i = 0; i < 30; i++) begin
			d   = 5'(rand_bits(3));
			imm = 16'(rand_bits(16));
			case (i % 3)
				0: send({mips_pkg::OP_SPECIAL, prev, prev2, d, 5'd0, mips_pkg::FN_SUBU});
				1: send({mips_pkg::OP_ADDIU, prev, d, imm});
				default: send({mips_pkg::OP_SPECIAL, prev2, prev, d, 5'd0, mips_pkg::FN_SRAV});
			endcase
			prev2 = prev;
			prev  = d;
		end
		drain("dependent_chains");
		lat_check = 1'b0;

		send({mips_pkg::OP_ORI, 5'd0, 5'd1, 16'h0000});
		send({mips_pkg::OP_ORI, 5'd0, 5'd2, 16'h0005});
		send({mips_pkg::OP_LUI, 5'd0, 5'd3, 16'h8123});
		send({mips_pkg::OP_SPECIAL, 5'd3, 5'd2, 5'd4, 5'd0, mips_pkg::FN_MOVN});
		send({mips_pkg::OP_SPECIAL, 5'd3, 5'd1, 5'd5, 5'd0, mips_pkg::FN_MOVN});
		send({mips_pkg::OP_SPECIAL, 5'd3, 5'd1, 5'd6, 5'd0, mips_pkg::FN_MOVZ});
		send({mips_pkg::OP_SPECIAL, 5'd3, 5'd2, 5'd7, 5'd0, mips_pkg::FN_MOVZ});
		send({mips_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h0007});    // r0 write dropped
		send({mips_pkg::OP_SPECIAL, 5'd0, 5'd3, 5'd5, 5'd0, mips_pkg::FN_OR});
		send({mips_pkg::OP_SPECIAL, 5'd3, 5'd2, 5'd0, 5'd0, mips_pkg::FN_MOVN});
		send({mips_pkg::OP_SPECIAL, 5'd0, 5'd0, 5'd6, 5'd0, mips_pkg::FN_OR});
		drain("conditional_moves");

		send({6'b111111, 26'h1234567});
		send({mips_pkg::OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'b111111});
		repeat (20) send(rand_inst());
		drain("invalid_opcode");

		bp_on = 1'b1;
		repeat (300) send(rand_inst());
		drain("back_pressure");
		bp_on = 1'b0;

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+sim
rtl/mips_pkg.sv
rtl/stage_reg.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/mips_core.sv
sim/tb_mips_core.sv
